// ==== tb.f ====
+incdir+src
src/mipsPkg.sv
src/regPortIf.sv
src/registerFile.sv
src/alu.sv
src/controlUnit.sv
src/mipsCpuBus.sv
verification/avalonMemModel.sv
verification/tbMipsCpu.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tbMipsCpu -o simTb
./obj_dir/simTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
grep -q "Test completed successfully" sim.log

// ==== verification/tbMipsCpu.sv ====
`timescale 1ns/1ps

module tbMipsCpu;
    localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
    localparam logic [31:0] DATA_ADDRESS = 32'hBFC00800;

    logic clk;
    logic reset;
    logic active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic write;
    logic read;
    logic waitrequest;
    logic [31:0] writedata;
    logic [3:0] byteenable;
    logic [31:0] readdata;

    int mismatchCount;
    int failureCount;
    logic [31:0] programWords [$];
    // Expected register contents as the program is assembled
    logic [31:0] model [32];

    always #5 clk = ~clk;

    mipsCpuBus DUT (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalonMemModel memModel (
        .clk(clk), .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest)
    );

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatchCount++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic reportFailure(input string what);
        failureCount++;
        $display("At %0t: %s", $time, what);
    endtask

    function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] sh);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // R-type instruction and its effect on the expected registers
    task automatic emitR(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
                         input logic [4:0] rt, input logic [4:0] sh);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        bit writes;
        a = model[rs];
        b = model[rt];
        writes = 1'b1;
        case (fn)
            6'd33: v = a + b;
            6'd35: v = a - b;
            6'd36: v = a & b;
            6'd37: v = a | b;
            6'd38: v = a ^ b;
            6'd42: v = {31'd0, $signed(a) < $signed(b)};
            6'd43: v = {31'd0, a < b};
            6'd0: v = b << sh;
            6'd2: v = b >> sh;
            6'd3: v = $signed(b) >>> sh;
            6'd4: v = b << a[4:0];
            6'd6: v = b >> a[4:0];
            6'd7: v = $signed(b) >>> a[4:0];
            default: begin
                v = '0;
                writes = 1'b0;
            end
        endcase
        if (writes && rd != 5'd0) begin
            model[rd] = v;
        end
        programWords.push_back(encR(fn, rd, rs, rt, sh));
    endtask

    task automatic emitI(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                         input logic [15:0] imm);
        logic [31:0] a;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] v;
        a = model[rs];
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            6'd10: v = {31'd0, $signed(a) < $signed(sext)};
            6'd11: v = {31'd0, a < sext};
            6'd12: v = a & zext;
            6'd13: v = a | zext;
            6'd14: v = a ^ zext;
            6'd15: v = {imm, 16'h0000};
            default: v = a + sext;
        endcase
        if (rt != 5'd0) begin
            model[rt] = v;
        end
        programWords.push_back(encI(op, rs, rt, imm));
    endtask

    task automatic startProgram();
        programWords.delete();
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
    endtask

    task automatic endProgram();
        // JR to the halt address with a no-op in the delay slot
        emitR(6'd8, 5'd0, 5'd0, 5'd0, 5'd0);
        programWords.push_back(32'h00000000);
    endtask

    task automatic loadAndReset();
        logic [31:0] w;
        reset = 1'b1;
        @(negedge clk);
        // Load while the core is held in reset
        foreach (programWords[i]) begin
            w = programWords[i];
            memModel.writeWord(RESET_VECTOR + 32'(i) * 4, {w[7:0], w[15:8], w[23:16], w[31:24]});
        end
        repeat (7) begin
            @(negedge clk);
            checkValue("read", 32'd0, {31'd0, read});
            checkValue("write", 32'd0, {31'd0, write});
            checkValue("active", 32'd1, {31'd0, active});
            checkValue("registerV0", 32'd0, registerV0);
        end
        reset = 1'b0;
    endtask

    task automatic runUntilHalt();
        int cycles;
        cycles = 0;
        while (active && cycles < 20000) begin
            @(negedge clk);
            cycles++;
            if (write) begin
                checkValue("byteenable", 32'hF, {28'd0, byteenable});
            end
        end
        assert (!active) else reportFailure("core did not halt before the timeout");
    endtask

    task automatic resetAndFirstFetch();
        int cycles;
        startProgram();
        endProgram();
        loadAndReset();
        cycles = 0;
        while (!read && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (read) else reportFailure("no fetch read after reset");
        if (read) begin
            checkValue("address", RESET_VECTOR, address);
            checkValue("byteenable", 32'hF, {28'd0, byteenable});
        end
        runUntilHalt();
    endtask

    task automatic aluOperations();
        startProgram();
        emitI(6'd9, 5'd0, 5'd8, 16'h1234);
        emitI(6'd15, 5'd0, 5'd9, 16'h8000);
        emitI(6'd13, 5'd9, 5'd9, 16'h00F0);
        emitR(6'd33, 5'd10, 5'd8, 5'd9, 5'd0);
        emitR(6'd35, 5'd11, 5'd8, 5'd9, 5'd0);
        emitR(6'd36, 5'd12, 5'd10, 5'd9, 5'd0);
        emitR(6'd37, 5'd13, 5'd11, 5'd8, 5'd0);
        emitR(6'd38, 5'd14, 5'd11, 5'd10, 5'd0);
        emitR(6'd42, 5'd15, 5'd9, 5'd8, 5'd0);
        emitR(6'd43, 5'd16, 5'd9, 5'd8, 5'd0);
        emitR(6'd0, 5'd17, 5'd0, 5'd8, 5'd8);
        emitR(6'd2, 5'd18, 5'd0, 5'd9, 5'd4);
        emitR(6'd3, 5'd19, 5'd0, 5'd9, 5'd4);
        emitI(6'd9, 5'd0, 5'd20, 16'd3);
        emitR(6'd4, 5'd21, 5'd20, 5'd8, 5'd0);
        emitR(6'd6, 5'd22, 5'd20, 5'd9, 5'd0);
        emitR(6'd7, 5'd23, 5'd20, 5'd9, 5'd0);
        emitI(6'd10, 5'd9, 5'd24, 16'hFFFF);
        emitI(6'd11, 5'd8, 5'd25, 16'hFFFF);
        emitI(6'd12, 5'd9, 5'd3, 16'hFFF0);
        emitI(6'd14, 5'd8, 5'd4, 16'hFFFF);
        // Fold every result into v0 with alternating add and xor
        emitR(6'd38, 5'd2, 5'd10, 5'd11, 5'd0);
        for (int r = 12; r <= 25; r++) begin
            emitR((r % 2 == 1) ? 6'd33 : 6'd38, 5'd2, 5'd2, 5'(r), 5'd0);
        end
        emitR(6'd33, 5'd2, 5'd2, 5'd3, 5'd0);
        emitR(6'd38, 5'd2, 5'd2, 5'd4, 5'd0);
        endProgram();
        loadAndReset();
        runUntilHalt();
        checkValue("registerV0", model[2], registerV0);
    endtask

    task automatic storeLoadUnderStalls();
        logic [31:0] stored;
        startProgram();
        emitI(6'd15, 5'd0, 5'd8, DATA_ADDRESS[31:16]);
        emitI(6'd13, 5'd8, 5'd8, DATA_ADDRESS[15:0]);
        emitI(6'd15, 5'd0, 5'd9, 16'hCAFE);
        emitI(6'd13, 5'd9, 5'd9, 16'hF00D);
        stored = model[9];
        programWords.push_back(encI(6'd43, 5'd8, 5'd9, 16'h0000));
        programWords.push_back(encI(6'd35, 5'd8, 5'd2, 16'h0000));
        endProgram();
        loadAndReset();
        runUntilHalt();
        checkValue("memory word", {stored[7:0], stored[15:8], stored[23:16], stored[31:24]},
                   memModel.readWord(DATA_ADDRESS));
        checkValue("registerV0", stored, registerV0);
    endtask

    task automatic branchesAndJump();
        logic [31:0] jumpTarget;
        startProgram();
        jumpTarget = (RESET_VECTOR + 32'd18 * 4) >> 2;
        programWords.push_back(encI(6'd9, 5'd0, 5'd2, 16'd0));
        programWords.push_back(encI(6'd9, 5'd0, 5'd8, 16'd5));
        programWords.push_back(encI(6'd9, 5'd0, 5'd9, 16'd5));
        programWords.push_back(encI(6'd4, 5'd8, 5'd9, 16'd2));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd1));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd100));
        programWords.push_back(encI(6'd5, 5'd8, 5'd9, 16'd2));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd2));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd4));
        programWords.push_back(encI(6'd4, 5'd8, 5'd0, 16'd2));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd8));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd16));
        programWords.push_back(encI(6'd5, 5'd8, 5'd0, 16'd2));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd32));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd64));
        programWords.push_back({6'd2, jumpTarget[25:0]});
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd128));
        programWords.push_back(encI(6'd9, 5'd2, 5'd2, 16'd256));
        endProgram();
        loadAndReset();
        runUntilHalt();
        // Delay slots always run so only 100, 64 and 256 are skipped
        checkValue("registerV0", 32'd1 + 32'd2 + 32'd4 + 32'd8 + 32'd16 + 32'd32 + 32'd128,
                   registerV0);
    endtask

    task automatic zeroRegisterAndHalt();
        startProgram();
        emitI(6'd9, 5'd0, 5'd2, 16'd7);
        emitI(6'd9, 5'd0, 5'd0, 16'h0055);
        emitR(6'd33, 5'd2, 5'd0, 5'd0, 5'd0);
        endProgram();
        loadAndReset();
        runUntilHalt();
        checkValue("registerV0", model[2], registerV0);
        repeat (40) begin
            @(negedge clk);
            assert (!(active || read || write)) else begin
                reportFailure("bus activity or active high after halt");
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        mismatchCount = 0;
        failureCount = 0;
        resetAndFirstFetch();
        aluOperations();
        storeLoadUnderStalls();
        branchesAndJump();
        zeroRegisterAndHalt();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verification/avalonMemModel.sv ====
`timescale 1ns/1ps

module avalonMemModel (
    input logic clk,
    input logic [31:0] address,
    input logic read,
    input logic write,
    input logic [31:0] writedata,
    input logic [3:0] byteenable,
    output logic [31:0] readdata,
    output logic waitrequest
);
    localparam logic [31:0] BASE_ADDRESS = 32'hBFC00000;
    localparam int WORD_COUNT = 16384;

    // Each word holds four little-endian bytes
    logic [31:0] mem [WORD_COUNT];
    logic [31:0] stallState;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] readWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - BASE_ADDRESS;
        if (offset < WORD_COUNT * 4) begin
            return mem[offset[15:2]];
        end
        // Outside the 64 KB window
        return addr ^ 32'h5A5AA5A5;
    endfunction

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] offset;
        offset = addr - BASE_ADDRESS;
        if (offset < WORD_COUNT * 4) begin
            mem[offset[15:2]] = data;
        end
    endtask

    initial begin
        for (int i = 0; i < WORD_COUNT; i++) begin
            mem[i] = (BASE_ADDRESS + 32'(i) * 4) ^ 32'hA5A55A5A;
        end
        stallState = 32'h2a192a81;
        waitrequest = 1'b0;
        readdata = '0;
    end

    // Slave outputs change on the falling edge
    always @(negedge clk) begin
        stallState = xorshift(stallState);
        waitrequest = (stallState[1:0] == 2'b00);
        if (read) begin
            readdata = readWord(address);
        end
    end

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[(address - BASE_ADDRESS) >> 2][b*8 +: 8] = writedata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== src/mipsCpuBus.sv ====
`timescale 1ns/1ps
`include "cpuConfig_macros.svh"

module mipsCpuBus (
    input logic clk,
    input logic reset,
    output logic active,
    output logic [`CPU_DATA_WIDTH-1:0] registerV0,
    output logic [`CPU_DATA_WIDTH-1:0] address,
    output logic write,
    output logic read,
    input logic waitrequest,
    output logic [`CPU_DATA_WIDTH-1:0] writedata,
    output logic [3:0] byteenable,
    input logic [`CPU_DATA_WIDTH-1:0] readdata
);
    import mipsPkg::*;

    aluOpT aluOp;
    wordT operandA;
    wordT operandB;
    logic [4:0] shamt;
    wordT aluResult;

    regPortIf regs ();

    controlUnit core (
        .clk(clk),
        .reset(reset),
        .regs(regs.core),
        .aluOp(aluOp),
        .operandA(operandA),
        .operandB(operandB),
        .shamt(shamt),
        .aluResult(aluResult),
        .address(address),
        .read(read),
        .write(write),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata),
        .active(active),
        .registerV0(registerV0)
    );

    registerFile registers (
        .clk(clk),
        .reset(reset),
        .port(regs.storage)
    );

    alu arith (
        .aluOp(aluOp),
        .operandA(operandA),
        .operandB(operandB),
        .shamt(shamt),
        .result(aluResult)
    );

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps
`include "cpuConfig_macros.svh"

module controlUnit (
    input logic clk,
    input logic reset,
    regPortIf.core regs,
    output mipsPkg::aluOpT aluOp,
    output mipsPkg::wordT operandA,
    output mipsPkg::wordT operandB,
    output logic [4:0] shamt,
    input mipsPkg::wordT aluResult,
    output mipsPkg::wordT address,
    output logic read,
    output logic write,
    input logic waitrequest,
    output mipsPkg::wordT writedata,
    output logic [3:0] byteenable,
    input mipsPkg::wordT readdata,
    output logic active,
    output mipsPkg::wordT registerV0
);
    import mipsPkg::*;

    localparam regAddrT V0_INDEX = 5'd2;

    cpuStateT state;
    decodedInstrT ir;
    wordT pc;
    wordT pendingTarget;
    logic pendingValid;
    wordT regA;
    wordT regB;
    wordT resultReg;

    regAddrT rsField;
    regAddrT rtField;
    regAddrT rdField;
    logic [4:0] shamtField;
    functT functField;
    logic [15:0] immField;
    logic [25:0] targetField;

    logic isRType;
    logic isJr;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic isJump;
    logic isFixedShift;
    logic isVariableShift;
    logic zeroExtImm;
    logic rKnown;
    logic iKnown;
    aluOpT rAluOp;
    aluOpT iAluOp;
    wordT immExtended;
    wordT pcPlus4;
    wordT branchTarget;
    logic branchTaken;
    logic redirect;
    wordT redirectTarget;
    logic startFetch;
    wordT fetchPc;

    // Memory holds little-endian bytes, the core works on big-endian words
    function automatic wordT swapBytes(input wordT value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    assign rsField = ir.body.f.rs;
    assign rtField = ir.body.f.rt;
    assign rdField = ir.body.f.low.r.rd;
    assign shamtField = ir.body.f.low.r.shamt;
    assign functField = ir.body.f.low.r.funct;
    assign immField = ir.body.f.low.immediate;
    assign targetField = ir.body.target;

    assign isRType = (ir.opcode == opSpecial);
    assign isJr = isRType && (functField == fnJr);
    assign isLoad = (ir.opcode == opLw);
    assign isStore = (ir.opcode == opSw);
    assign isBranch = (ir.opcode == opBeq) || (ir.opcode == opBne);
    assign isJump = (ir.opcode == opJump);
    assign isFixedShift = isRType && (functField inside {fnSll, fnSrl, fnSra});
    assign isVariableShift = isRType && (functField inside {fnSllv, fnSrlv, fnSrav});
    assign zeroExtImm = ir.opcode inside {opAndi, opOri, opXori};

    // R-type decode, JR and unknown codes are not ALU work
    always_comb begin
        rKnown = 1'b1;
        case (functField)
            fnAddu: rAluOp = aluAdd;
            fnSubu: rAluOp = aluSub;
            fnAnd: rAluOp = aluAnd;
            fnOr: rAluOp = aluOr;
            fnXor: rAluOp = aluXor;
            fnSlt: rAluOp = aluSlt;
            fnSltu: rAluOp = aluSltu;
            fnSll, fnSllv: rAluOp = aluSll;
            fnSrl, fnSrlv: rAluOp = aluSrl;
            fnSra, fnSrav: rAluOp = aluSra;
            default: begin
                rAluOp = aluAdd;
                rKnown = 1'b0;
            end
        endcase
    end

    // Immediate decode, loads and stores fall through to address add
    always_comb begin
        iKnown = 1'b1;
        case (ir.opcode)
            opAddiu: iAluOp = aluAdd;
            opSlti: iAluOp = aluSlt;
            opSltiu: iAluOp = aluSltu;
            opAndi: iAluOp = aluAnd;
            opOri: iAluOp = aluOr;
            opXori: iAluOp = aluXor;
            opLui: iAluOp = aluLui;
            default: begin
                iAluOp = aluAdd;
                iKnown = 1'b0;
            end
        endcase
    end

    assign immExtended = zeroExtImm ? {16'h0000, immField} : {{16{immField[15]}}, immField};

    assign aluOp = isRType ? rAluOp : iAluOp;
    assign operandA = isFixedShift ? '0 : regA;
    assign operandB = isRType ? regB : immExtended;
    assign shamt = isVariableShift ? '0 : shamtField;

    // Branch and jump targets, taken after the delay slot
    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immExtended[29:0], 2'b00};
    assign branchTaken = isBranch && ((regA == regB) == (ir.opcode == opBeq));
    assign redirect = (state == execute) && (isJump || isJr || branchTaken);

    always_comb begin
        if (isJump) begin
            redirectTarget = {pcPlus4[31:28], targetField, 2'b00};
        end else if (isJr) begin
            redirectTarget = regA;
        end else begin
            redirectTarget = branchTarget;
        end
    end

    // End of an instruction, or the first fetch after reset
    always_comb begin
        case (state)
            fetch: startFetch = !read;
            execute: startFetch = !(rKnown && isRType || iKnown || isLoad || isStore);
            memory: startFetch = isStore && !waitrequest;
            writeBack: startFetch = 1'b1;
            default: startFetch = 1'b0;
        endcase
    end

    assign fetchPc = (state == fetch) ? pc : (pendingValid ? pendingTarget : pcPlus4);

    assign regs.rsAddr = (state == halted) ? V0_INDEX : rsField;
    assign regs.rtAddr = rtField;
    assign regs.writeEnable = (state == writeBack);
    assign regs.writeAddr = isRType ? rdField : rtField;
    assign regs.writeData = resultReg;

    assign byteenable = 4'b1111;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch;
            pc <= `CPU_RESET_VECTOR;
            pendingValid <= 1'b0;
            read <= 1'b0;
            write <= 1'b0;
            active <= 1'b1;
            registerV0 <= '0;
        end else begin
            case (state)
                fetch: begin
                    if (read && !waitrequest) begin
                        read <= 1'b0;
                        state <= decode;
                    end
                end
                decode: begin
                    state <= execute;
                end
                execute: begin
                    if (isRType && rKnown || iKnown) begin
                        state <= writeBack;
                    end else if (isLoad || isStore) begin
                        read <= isLoad;
                        write <= isStore;
                        state <= memory;
                    end
                end
                memory: begin
                    if (!waitrequest) begin
                        read <= 1'b0;
                        write <= 1'b0;
                        if (isLoad) begin
                            state <= writeBack;
                        end
                    end
                end
                halted: begin
                    active <= 1'b0;
                    registerV0 <= regs.rsData;
                end
                default: begin
                    // WriteBack leaves through the fetch launch below
                end
            endcase

            if (startFetch) begin
                pc <= fetchPc;
                pendingValid <= redirect;
                if (fetchPc == `CPU_HALT_ADDRESS) begin
                    state <= halted;
                end else begin
                    state <= fetch;
                    read <= 1'b1;
                end
            end
        end
    end

    // Instruction, operand and bus payload registers
    always_ff @(posedge clk) begin
        if (state == fetch && read && !waitrequest) begin
            ir <= decodedInstrT'(swapBytes(readdata));
        end
        if (state == decode) begin
            regA <= regs.rsData;
            regB <= regs.rtData;
        end
        if (state == execute) begin
            resultReg <= aluResult;
            address <= aluResult;
            writedata <= swapBytes(regB);
        end
        if (state == memory && isLoad && !waitrequest) begin
            resultReg <= swapBytes(readdata);
        end
        if (startFetch) begin
            address <= fetchPc;
            pendingTarget <= redirectTarget;
        end
    end

    readWriteExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(read && write)
    );

    // Avalon hold rule while the slave stalls
    addressStableInStall: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && (read || write)
    );

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input mipsPkg::aluOpT aluOp,
    input mipsPkg::wordT operandA,
    input mipsPkg::wordT operandB,
    input logic [4:0] shamt,
    output mipsPkg::wordT result
);
    import mipsPkg::*;

    logic [4:0] shiftAmount;
    logic signedLess;
    logic unsignedLess;

    // Control unit zeroes whichever amount source is unused
    assign shiftAmount = shamt | operandA[4:0];

    assign signedLess = $signed(operandA) < $signed(operandB);
    assign unsignedLess = operandA < operandB;

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = operandA + operandB;
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluAnd: begin
                result = operandA & operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluXor: begin
                result = operandA ^ operandB;
            end
            aluSlt: begin
                result = wordT'(signedLess);
            end
            aluSltu: begin
                result = wordT'(unsignedLess);
            end
            // Shifts act on the rt operand
            aluSll: begin
                result = operandB << shiftAmount;
            end
            aluSrl: begin
                result = operandB >> shiftAmount;
            end
            aluSra: begin
                result = wordT'($signed(operandB) >>> shiftAmount);
            end
            aluLui: begin
                result = {operandB[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`include "cpuConfig_macros.svh"

module registerFile (
    input logic clk,
    input logic reset,
    regPortIf.storage port
);
    import mipsPkg::*;

    wordT regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (port.writeEnable && port.writeAddr != '0) begin
            // Register zero never takes a write
            regs[port.writeAddr] <= port.writeData;
        end
    end

    assign port.rsData = (port.rsAddr == '0) ? '0 : regs[port.rsAddr];
    assign port.rtData = (port.rtAddr == '0) ? '0 : regs[port.rtAddr];

    // Control unit must present a clean destination on every write
    writeAddrKnown: assert property (
        @(posedge clk) disable iff (reset)
        port.writeEnable |-> !$isunknown(port.writeAddr)
    );

endmodule

// ==== src/regPortIf.sv ====
`timescale 1ns/1ps

interface regPortIf;
    import mipsPkg::*;

    // Two combinational read ports
    regAddrT rsAddr;
    regAddrT rtAddr;
    wordT rsData;
    wordT rtData;

    // One write port, taken at the clock edge
    logic writeEnable;
    regAddrT writeAddr;
    wordT writeData;

    modport core (
        output rsAddr, rtAddr, writeEnable, writeAddr, writeData,
        input rsData, rtData
    );

    modport storage (
        input rsAddr, rtAddr, writeEnable, writeAddr, writeData,
        output rsData, rtData
    );

endinterface

// ==== src/mipsPkg.sv ====
`include "cpuConfig_macros.svh"

package mipsPkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] wordT;
    typedef logic [`CPU_REG_ADDR_WIDTH-1:0] regAddrT;

    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        memory,
        writeBack,
        halted
    } cpuStateT;

    // Primary opcodes, unknown values decode as no-ops
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opJump    = 6'd2,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOpT;

    // Low half of the word, R-type fields or the 16-bit immediate
    typedef struct packed {
        regAddrT rd;
        logic [4:0] shamt;
        functT funct;
    } rTypeFieldsT;

    typedef union packed {
        rTypeFieldsT r;
        logic [15:0] immediate;
    } lowFieldsT;

    typedef struct packed {
        regAddrT rs;
        regAddrT rt;
        lowFieldsT low;
    } regFieldsT;

    // J-type target overlays everything below the opcode
    typedef union packed {
        regFieldsT f;
        logic [25:0] target;
    } operandFieldsT;

    typedef struct packed {
        opcodeT opcode;
        operandFieldsT body;
    } decodedInstrT;

endpackage

// ==== src/cpuConfig_macros.svh ====
`ifndef CPU_CONFIG_MACROS_SVH
`define CPU_CONFIG_MACROS_SVH

// Datapath and bus address width
`define CPU_DATA_WIDTH 32

// Register file geometry
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_WIDTH 5

// First instruction fetched after reset
`define CPU_RESET_VECTOR 32'hBFC00000

// A fetch from here stops the core
`define CPU_HALT_ADDRESS 32'h00000000

`endif
